/* logic/csa_defines.svh */
`ifndef CSA_DEFINES_SVH
`define CSA_DEFINES_SVH

// one parameter word of the record.
`define CSA_WORD_W 32

// key as held in the record.
`define CSA_KEY_W 48

// keystream result and working state.
`define CSA_RES_W 64

// zero bits above the key, filling two words.
`define CSA_PAD_W (2 * `CSA_WORD_W - `CSA_KEY_W)

// queue depths.
`define CSA_IN_DEPTH 22
`define CSA_OUT_DEPTH 23

// left rotation applied each round.
`define CSA_ROT 5

`endif

/* logic/csa_rec_pkg.sv */
`include "csa_defines.svh"

package csa_rec_pkg;

	// block sits in the low word, times_start in the top word.
	typedef struct packed {
		logic [`CSA_WORD_W-1:0] times_start;
		logic [`CSA_WORD_W-1:0] times;
		logic [`CSA_PAD_W-1:0]  pad; // always zero.
		logic [`CSA_KEY_W-1:0]  key;
		logic [`CSA_WORD_W-1:0] block;
	} csa_in_rec_t;

	// fields the engine works on.
	typedef struct packed {
		logic [`CSA_WORD_W-1:0] times_start;
		logic [`CSA_WORD_W-1:0] times;
		logic [`CSA_KEY_W-1:0]  key;
		logic [`CSA_WORD_W-1:0] block;
	} csa_job_t;

	// input fields echoed below the result.
	typedef struct packed {
		logic [`CSA_RES_W-1:0]  result;
		logic [`CSA_WORD_W-1:0] times_start;
		logic [`CSA_WORD_W-1:0] times;
		logic [`CSA_PAD_W-1:0]  pad;
		logic [`CSA_KEY_W-1:0]  key;
		logic [`CSA_WORD_W-1:0] block;
	} csa_out_rec_t;

endpackage

/* logic/csa_ctrl_pkg.sv */
package csa_ctrl_pkg;

	// round engine FSM.
	typedef enum logic [1:0] {
		ENG_IDLE = 2'd0, // waiting for start.
		ENG_LOAD = 2'd1, // initial state and counters.
		ENG_RUN  = 2'd2, // one round per cycle.
		ENG_DONE = 2'd3  // result presented for one cycle.
	} csa_eng_state_e;

endpackage

/* logic/csa_fifo.sv */
`timescale 1ns/100ps

module csa_fifo #(
	parameter int DATA_W = 32,
	parameter int DEPTH  = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              wen_i,
	input  logic              ren_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              full_o,
	output logic              empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [DATA_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wptr_q;
	logic [PTR_W-1:0]  rptr_q;
	logic [CNT_W-1:0]  count_q;
	logic              do_wr;
	logic              do_rd;

	// depth need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign do_wr   = wen_i && !full_o; // drop when full.
	assign do_rd   = ren_i && !empty_o; // drop when empty.
	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr_q  <= '0;
			rptr_q  <= '0;
			count_q <= '0;
		end else begin
			if (do_wr) begin
				wptr_q <= next_ptr(wptr_q);
			end
			if (do_rd) begin
				rptr_q <= next_ptr(rptr_q);
			end
			case ({do_wr, do_rd})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q; // both or neither.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wptr_q] <= wdata_i;
		end
		if (do_rd) begin
			rdata_o <= mem[rptr_q]; // held until the next read.
		end
	end

endmodule

/* logic/csa_round_engine.sv */
`timescale 1ns/100ps
`include "csa_defines.svh"

module csa_round_engine (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start_i,
	input  csa_rec_pkg::csa_job_t      job_i,
	output logic                       idle_o,
	output logic                       done_o,
	output csa_rec_pkg::csa_out_rec_t  rec_o
);

	localparam int LOW_W = `CSA_RES_W - `CSA_KEY_W;

	csa_ctrl_pkg::csa_eng_state_e state_q;
	csa_ctrl_pkg::csa_eng_state_e state_d;

	csa_rec_pkg::csa_job_t  job_q;
	logic [`CSA_RES_W-1:0]  st_q;
	logic [`CSA_WORD_W-1:0] idx_q;
	logic [`CSA_WORD_W-1:0] cnt_q;
	logic [`CSA_RES_W-1:0]  init_st;

	// rotate left, then mix in block and round index.
	function automatic logic [`CSA_RES_W-1:0] csa_round(
		input logic [`CSA_RES_W-1:0]  st,
		input logic [`CSA_WORD_W-1:0] blk,
		input logic [`CSA_WORD_W-1:0] idx
	);
		logic [`CSA_RES_W-1:0] rot;
		rot = {st[`CSA_RES_W-`CSA_ROT-1:0], st[`CSA_RES_W-1:`CSA_RES_W-`CSA_ROT]};
		return rot ^ {blk, idx};
	endfunction

	assign init_st = {job_q.key, job_q.block[LOW_W-1:0]}; // key on top.

	always_comb begin
		state_d = state_q;
		case (state_q)
			csa_ctrl_pkg::ENG_IDLE: begin
				if (start_i) begin
					state_d = csa_ctrl_pkg::ENG_LOAD;
				end
			end
			csa_ctrl_pkg::ENG_LOAD: begin
				if (job_q.times == '0) begin
					state_d = csa_ctrl_pkg::ENG_DONE; // no rounds.
				end else begin
					state_d = csa_ctrl_pkg::ENG_RUN;
				end
			end
			csa_ctrl_pkg::ENG_RUN: begin
				if (cnt_q == `CSA_WORD_W'(1)) begin
					state_d = csa_ctrl_pkg::ENG_DONE; // last round.
				end
			end
			default: begin
				state_d = csa_ctrl_pkg::ENG_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= csa_ctrl_pkg::ENG_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		case (state_q)
			csa_ctrl_pkg::ENG_IDLE: begin
				if (start_i) begin
					job_q <= job_i;
				end
			end
			csa_ctrl_pkg::ENG_LOAD: begin
				st_q  <= init_st;
				idx_q <= job_q.times_start;
				cnt_q <= job_q.times;
			end
			csa_ctrl_pkg::ENG_RUN: begin
				st_q  <= csa_round(st_q, job_q.block, idx_q);
				idx_q <= idx_q + 1'b1; // wraps at 32 bits.
				cnt_q <= cnt_q - 1'b1;
			end
			default: begin
				st_q <= st_q;
			end
		endcase
	end

	assign idle_o = (state_q == csa_ctrl_pkg::ENG_IDLE);
	assign done_o = (state_q == csa_ctrl_pkg::ENG_DONE);

	always_comb begin
		rec_o             = '0; // pad stays zero.
		rec_o.result      = st_q;
		rec_o.times_start = job_q.times_start;
		rec_o.times       = job_q.times;
		rec_o.key         = job_q.key;
		rec_o.block       = job_q.block;
	end

endmodule

/* logic/csa_calc_wrap.sv */
`timescale 1ns/100ps
`include "csa_defines.svh"

module csa_calc_wrap (
	input  logic                       clk,
	input  logic                       rst_n,
	input  csa_rec_pkg::csa_in_rec_t   csa_in_i,
	input  logic                       csa_in_wen_i,
	output logic                       csa_in_full_o,
	output csa_rec_pkg::csa_out_rec_t  csa_out_o,
	input  logic                       csa_out_ren_i,
	output logic                       csa_out_ready_o
);

	csa_rec_pkg::csa_in_rec_t  in_rdata;
	logic                      in_empty;
	logic                      in_ren;
	logic                      ren_q;
	logic                      start_q;
	csa_rec_pkg::csa_job_t     job_q;
	logic                      eng_idle;
	logic                      eng_done;
	csa_rec_pkg::csa_out_rec_t eng_rec;
	logic                      out_empty;

	csa_fifo #(
		.DATA_W ($bits(csa_rec_pkg::csa_in_rec_t)),
		.DEPTH  (`CSA_IN_DEPTH)
	) i_in_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wdata_i (csa_in_i),
		.wen_i   (csa_in_wen_i),
		.ren_i   (in_ren),
		.rdata_o (in_rdata),
		.full_o  (csa_in_full_o),
		.empty_o (in_empty)
	);

	// one record in flight; hold off while a read or start is pending.
	assign in_ren = !in_empty && out_empty && eng_idle && !ren_q && !start_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ren_q   <= 1'b0;
			start_q <= 1'b0;
		end else begin
			ren_q   <= in_ren;
			start_q <= ren_q; // job register valid now.
		end
	end

	// unpack once the fifo data is valid.
	always_ff @(posedge clk) begin
		if (ren_q) begin
			job_q.block       <= in_rdata.block;
			job_q.key         <= in_rdata.key;
			job_q.times       <= in_rdata.times;
			job_q.times_start <= in_rdata.times_start;
		end
	end

	csa_round_engine i_eng (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (start_q),
		.job_i   (job_q),
		.idle_o  (eng_idle),
		.done_o  (eng_done),
		.rec_o   (eng_rec)
	);

	csa_fifo #(
		.DATA_W ($bits(csa_rec_pkg::csa_out_rec_t)),
		.DEPTH  (`CSA_OUT_DEPTH)
	) i_out_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wdata_i (eng_rec),
		.wen_i   (eng_done),
		.ren_i   (csa_out_ren_i),
		.rdata_o (csa_out_o),
		.full_o  (),
		.empty_o (out_empty)
	);

	assign csa_out_ready_o = !out_empty;

endmodule

/* bench/csa_calc_chk.sv */
`timescale 1ns/100ps

module csa_calc_chk (
	input logic                         clk,
	input logic                         rst_n,
	input logic                         out_wen_i,
	input logic                         out_empty_i,
	input logic                         start_i,
	input csa_ctrl_pkg::csa_eng_state_e eng_state_i,
	input logic                         out_ready_i
);

	// only one record in flight.
	a_out_write_empty: assert property (
		@(posedge clk) disable iff (!rst_n) out_wen_i |-> out_empty_i
	) else $error("output FIFO written while it still holds a record");

	a_start_idle: assert property (
		@(posedge clk) disable iff (!rst_n) start_i |-> (eng_state_i == csa_ctrl_pkg::ENG_IDLE)
	) else $error("engine start raised while the engine was busy");

	a_ready_after_reset: assert property (
		@(posedge clk) !rst_n |=> !out_ready_i
	) else $error("output ready high in the cycle after reset");

endmodule

bind csa_calc_wrap csa_calc_chk i_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.out_wen_i   (eng_done),
	.out_empty_i (out_empty),
	.start_i     (start_q),
	.eng_state_i (i_eng.state_q),
	.out_ready_i (csa_out_ready_o)
);

/* bench/csa_calc_tb.sv */
`timescale 1ns/100ps
`include "csa_defines.svh"

module csa_calc_tb;

	localparam int NUM_RECS       = 40;
	localparam int MAX_TIMES      = 40;
	localparam int TIMEOUT_CYCLES = NUM_RECS * (MAX_TIMES + 10) + 200;

	logic                      clk;
	logic                      rst_n;
	csa_rec_pkg::csa_in_rec_t  csa_in;
	logic                      csa_in_wen;
	logic                      csa_in_full;
	csa_rec_pkg::csa_out_rec_t csa_out;
	logic                      csa_out_ren;
	logic                      csa_out_ready;

	csa_rec_pkg::csa_out_rec_t exp_q[$];
	logic [15:0]               lfsr = 16'd46;
	logic                      hold;
	int                        read_delay;
	int                        cycles;

	csa_calc_wrap i_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.csa_in_i        (csa_in),
		.csa_in_wen_i    (csa_in_wen),
		.csa_in_full_o   (csa_in_full),
		.csa_out_o       (csa_out),
		.csa_out_ren_i   (csa_out_ren),
		.csa_out_ready_o (csa_out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	// keystream model.
	function automatic logic [`CSA_RES_W-1:0] csa_ref(input csa_rec_pkg::csa_in_rec_t rec);
		logic [`CSA_RES_W-1:0]  st;
		logic [`CSA_WORD_W-1:0] idx;
		int unsigned            n;
		st  = {rec.key, rec.block[15:0]};
		idx = rec.times_start;
		for (n = 0; n < rec.times; n++) begin
			st  = (st << `CSA_ROT) | (st >> (`CSA_RES_W - `CSA_ROT));
			st  = st ^ {rec.block, idx};
			idx = idx + 1; // wraps at 32 bits.
		end
		return st;
	endfunction

	function automatic csa_rec_pkg::csa_out_rec_t expect_rec(input csa_rec_pkg::csa_in_rec_t rec);
		csa_rec_pkg::csa_out_rec_t exp;
		exp             = '0;
		exp.result      = csa_ref(rec);
		exp.times_start = rec.times_start;
		exp.times       = rec.times;
		exp.key         = rec.key;
		exp.block       = rec.block;
		return exp;
	endfunction

	function automatic csa_rec_pkg::csa_in_rec_t make_rec(
		input logic [`CSA_WORD_W-1:0] times,
		input logic [`CSA_WORD_W-1:0] times_start
	);
		csa_rec_pkg::csa_in_rec_t rec;
		logic [31:0]              hi;
		rec              = '0;
		rec.block        = rand_bits(32);
		rec.key[31:0]    = rand_bits(32);
		hi               = rand_bits(16);
		rec.key[47:32]   = hi[15:0];
		rec.times        = times;
		rec.times_start  = times_start;
		return rec;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_rec(
		input string                     name,
		input csa_rec_pkg::csa_out_rec_t got,
		input csa_rec_pkg::csa_out_rec_t exp
	);
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			stop_on_error("output record differs from the model");
		end
	endtask

	task automatic check_result(
		input string                 name,
		input logic [`CSA_RES_W-1:0] got,
		input logic [`CSA_RES_W-1:0] exp
	);
		if (got !== exp) begin
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
			stop_on_error("keystream result differs from the model");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b exp %b", $time, name, got, exp);
			stop_on_error("status flag has the wrong level");
		end
	endtask

	// called on a falling edge, returns on one.
	task automatic send_rec(input csa_rec_pkg::csa_in_rec_t rec);
		while (csa_in_full) @(negedge clk);
		csa_in     = rec;
		csa_in_wen = 1'b1;
		exp_q.push_back(expect_rec(rec));
		@(negedge clk);
		csa_in_wen = 1'b0;
	endtask

	task automatic drain;
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	// host side and scoreboard.
	initial begin : compare_proc
		csa_rec_pkg::csa_out_rec_t exp;
		int                        wait_cnt;
		csa_out_ren = 1'b0;
		wait_cnt    = 0;
		forever begin
			@(negedge clk);
			if (csa_out_ren) begin
				csa_out_ren = 1'b0;
				if (exp_q.size() == 0) begin
					stop_on_error("a record came out that was never written");
				end else begin
					exp = exp_q.pop_front();
					check_result("csa_out_o.result", csa_out.result, exp.result);
					check_rec("csa_out_o", csa_out, exp);
				end
			end else if (rst_n && csa_out_ready && !hold) begin
				if (wait_cnt < read_delay) begin
					wait_cnt++;
				end else begin
					csa_out_ren = 1'b1;
					wait_cnt    = 0;
				end
			end
		end
	end

	initial begin : timeout_proc
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the records did not all come back within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	initial begin : main_proc
		csa_in     = '0;
		csa_in_wen = 1'b0;
		hold       = 1'b0;
		read_delay = 0;
		rst_n      = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		check_flag("csa_out_ready_o", csa_out_ready, 1'b0);
		check_flag("csa_in_full_o", csa_in_full, 1'b0);
		repeat (20) @(negedge clk);
		check_flag("csa_out_ready_o", csa_out_ready, 1'b0); // nothing written yet.

		send_rec(make_rec(32'd0, rand_bits(32)));
		send_rec(make_rec(32'd1, rand_bits(32)));
		repeat (8) send_rec(make_rec(rand_bits(6) % 41, rand_bits(32)));
		drain();

		// round index crosses the 32-bit limit.
		send_rec(make_rec(32'd12, 32'hffff_fffa));
		send_rec(make_rec(32'd3, 32'hffff_ffff));
		drain();

		// park one result so admission stalls, then fill the input queue.
		hold = 1'b1;
		send_rec(make_rec(rand_bits(6) % 41, rand_bits(32)));
		while (!csa_out_ready) @(negedge clk);
		repeat (`CSA_IN_DEPTH) send_rec(make_rec(rand_bits(6) % 41, rand_bits(32)));
		check_flag("csa_in_full_o", csa_in_full, 1'b1);
		hold = 1'b0;
		drain();

		read_delay = 25; // slow host.
		repeat (5) send_rec(make_rec(rand_bits(6) % 41, rand_bits(32)));
		drain();
		read_delay = 0;

		repeat (4) @(negedge clk);
		check_flag("csa_out_ready_o", csa_out_ready, 1'b0);
		check_flag("csa_in_full_o", csa_in_full, 1'b0);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* sim.f */
+incdir+logic
logic/csa_rec_pkg.sv
logic/csa_ctrl_pkg.sv
logic/csa_fifo.sv
logic/csa_round_engine.sv
logic/csa_calc_wrap.sv
bench/csa_calc_chk.sv
bench/csa_calc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the scrambler testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module csa_calc_tb -o csa_calc_sim

# the simulator exits non-zero on $fatal; the log decides the outcome.
./obj_dir/csa_calc_sim 2>&1 | tee sim.log || true

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "run.sh: testbench reported a failure"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "run.sh: simulation ended without a result line"
	exit 1
fi
echo "run.sh: testbench passed"
